// File: testbench/commit_trace_cases.txt
# D v pc insn rd we v pc insn rd we (bundle)   C seq data exc cause (completion)
# X slot pc insn rd we data exc cause (expected commit, program order)   all fields hex
D 1 400 c0de0000 01 1 1 401 c0de0001 02 1
D 1 402 c0de0002 03 1 1 403 c0de0003 04 1
C 3 50000003 0 0
C 2 50000002 0 0
C 1 50000001 0 0
C 0 50000000 0 0
X 0 400 c0de0000 01 1 50000000 0 0
X 1 401 c0de0001 02 1 50000001 0 0
X 0 402 c0de0002 03 1 50000002 0 0
X 1 403 c0de0003 04 1 50000003 0 0
D 1 404 c0de0004 05 1 1 405 c0de0005 00 0
D 1 406 c0de0006 07 1 1 407 c0de0007 08 1
D 1 408 c0de0008 09 1 1 409 c0de0009 0a 1
C 4 50000004 0 0
C 5 50000005 0 0
C 7 50000007 0 0
C 6 50000006 0 0
C 9 50000009 0 0
C 8 50000008 0 0
X 0 404 c0de0004 05 1 50000004 0 0
X 0 405 c0de0005 00 0 50000005 0 0
X 0 406 c0de0006 07 1 50000006 0 0
X 1 407 c0de0007 08 1 50000007 0 0
X 0 408 c0de0008 09 1 50000008 0 0
X 1 409 c0de0009 0a 1 50000009 0 0
D 1 40a c0de000a 0b 1 1 40b c0de000b 0c 1
D 1 40c c0de000c 00 0 1 40d c0de000d 0e 1
D 1 40e c0de000e 0f 1 1 40f c0de000f 10 1
C a 5000000a 0 0
C b 5000000b 0 0
C d 5000000d 0 0
C c 5000000c 0 0
C f 5000000f 0 0
C e 5000000e 0 0
X 0 40a c0de000a 0b 1 5000000a 0 0
X 0 40b c0de000b 0c 1 5000000b 0 0
X 0 40c c0de000c 00 0 5000000c 0 0
X 1 40d c0de000d 0e 1 5000000d 0 0
X 0 40e c0de000e 0f 1 5000000e 0 0
X 1 40f c0de000f 10 1 5000000f 0 0
D 1 410 c0de0010 11 1 1 411 c0de0011 12 1
C 11 50000011 0 0
C 10 50000010 1 0b
X 0 410 c0de0010 11 1 50000010 1 0b
D 1 800 beef0000 1f 1 0 0 0 0 0
C 0 600000aa 0 0
X 0 800 beef0000 1f 1 600000aa 0 0

// File: project.f
logic/trace_pkg.sv
logic/rob_ptrs.sv
logic/commit_fsm.sv
logic/commit_shadow.sv
logic/commit_trace_top.sv
testbench/tb_clock.sv
testbench/commit_trace_chk.sv
testbench/commit_trace_tb.sv

// File: testbench/commit_trace_tb.sv
`timescale 1ns/10ps

module commit_trace_tb;

   logic                          clk;
   logic                          arst_n;
   trace_pkg::dispatch_bundle_t   dispatch;
   trace_pkg::completion_t        complete;
   logic [trace_pkg::num_irq-1:0] irr;
   logic                          dispatch_ready;
   trace_pkg::trace_rec_t         trace;
   logic                          flush;

   logic [trace_pkg::num_irq-1:0] irr_at_edge;
   logic                          flush_due;
   string                         stim_q[$];
   trace_pkg::trace_slot_t        exp_slot_q[$];
   int                            exp_pos_q[$];
   int                            fd;
   int                            case_count = 0;
   bit                            cases_loaded = 1'b0;
   int                            commit_idx = 0;
   int                            slot_errors = 0;
   int                            irr_errors = 0;
   int                            order_errors = 0;
   int                            level_errors = 0;

   tb_clock i_clock
   (
      .clk (clk)
   );

   commit_trace_top i_dut
   (
      .clk            (clk),
      .arst_n         (arst_n),
      .dispatch       (dispatch),
      .complete       (complete),
      .irr            (irr),
      .dispatch_ready (dispatch_ready),
      .trace          (trace),
      .flush          (flush)
   );

   bind commit_trace_top commit_trace_chk i_chk
   (
      .clk            (clk),
      .arst_n         (arst_n),
      .dispatch       (dispatch),
      .dispatch_ready (dispatch_ready),
      .trace          (trace),
      .flush          (flush)
   );

   // Bank is seq mod 2, id is (seq div 2) mod 8
   function automatic trace_pkg::rob_tag_t seq_tag(input logic [31:0] seq);
      trace_pkg::rob_tag_t tag;
      tag.bank = 1'(seq % trace_pkg::commit_w);
      tag.id   = 3'((seq / trace_pkg::commit_w) % trace_pkg::bank_depth);
      return tag;
   endfunction

   task automatic compare_slot(input string name, input trace_pkg::trace_slot_t exp,
                               input trace_pkg::trace_slot_t act);
      if (act !== exp)
      begin
         $display("ERROR %s expected %h actual %h", name, exp, act);
         slot_errors++;
      end
   endtask

   task automatic compare_irr(input string name, input logic [trace_pkg::num_irq-1:0] exp,
                              input logic [trace_pkg::num_irq-1:0] act);
      if (act !== exp)
      begin
         $display("ERROR %s expected %h actual %h", name, exp, act);
         irr_errors++;
      end
   endtask

   task automatic compare_level(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("ERROR %s expected %b actual %b", name, exp, act);
         level_errors++;
      end
   endtask

   task automatic compare_pos(input string name, input int exp, input int act);
      if (act != exp)
      begin
         $display("ERROR %s slot index expected %0d actual %0d", name, exp, act);
         order_errors++;
      end
   endtask

   task automatic check_commit(input int pos, input trace_pkg::trace_slot_t act);
      string                  name;
      trace_pkg::trace_slot_t exp;
      name = $sformatf("commit %0d", commit_idx);
      if (exp_slot_q.size() == 0)
      begin
         $display("Unexpected commit in slot %0d at pc %h, no record was left to expect",
                  pos, act.pc);
         order_errors++;
      end
      else
      begin
         exp = exp_slot_q.pop_front();
         compare_pos(name, exp_pos_q.pop_front(), pos);
         compare_slot(name, exp, act);
         if (exp.excp)
            flush_due = 1'b1;
      end
      commit_idx++;
   endtask

   task automatic load_cases();
      string                  line;
      logic [31:0]            f [8];
      trace_pkg::trace_slot_t exp;
      while ($fgets(line, fd) != 0)
      begin
         if (line.len() > 0 && (line[0] == "D" || line[0] == "C"))
         begin
            stim_q.push_back(line);
            case_count++;
         end
         else if (line.len() > 0 && line[0] == "X")
         begin
            void'($sscanf(line, "X %h %h %h %h %h %h %h %h",
                          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]));
            exp       = '0;
            exp.valid = 1'b1;
            exp.pc    = f[1][trace_pkg::pc_w-1:0];
            exp.insn  = f[2];
            exp.rd    = f[3][trace_pkg::lrf_aw-1:0];
            exp.rd_we = f[4][0];
            exp.data  = f[5];
            exp.excp  = f[6][0];
            // Vector is the cause times four
            if (f[6][0])
               exp.excp_vect = 8'(f[7] * 4);
            exp_pos_q.push_back(f[0]);
            exp_slot_q.push_back(exp);
            case_count++;
         end
      end
   endtask

   task automatic step();
      @(negedge clk);
      dispatch = '0;
      complete = '0;
      irr      = 8'($urandom);
   endtask

   task automatic run_cases();
      logic [31:0]                 f [10];
      trace_pkg::dispatch_bundle_t bundle;
      trace_pkg::completion_t      comp;
      foreach (stim_q[n])
      begin
         if (stim_q[n][0] == "D")
         begin
            void'($sscanf(stim_q[n], "D %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                          f[3], f[4], f[5], f[6], f[7], f[8], f[9]));
            for (int s = 0; s < trace_pkg::issue_w; s++)
            begin
               bundle.slot[s].valid = f[5*s][0];
               bundle.slot[s].pc    = f[5*s+1][trace_pkg::pc_w-1:0];
               bundle.slot[s].insn  = f[5*s+2];
               bundle.slot[s].rd    = f[5*s+3][trace_pkg::lrf_aw-1:0];
               bundle.slot[s].rd_we = f[5*s+4][0];
            end
            while (!dispatch_ready)
               step();
            dispatch = bundle;
         end
         else
         begin
            void'($sscanf(stim_q[n], "C %h %h %h %h", f[0], f[1], f[2], f[3]));
            comp.valid = 1'b1;
            comp.tag   = seq_tag(f[0]);
            comp.data  = f[1];
            comp.exc   = f[2][0];
            comp.cause = f[3][trace_pkg::cause_w-1:0];
            complete   = comp;
         end
         step();
         // Gap of at least two cycles so a push lands before its completion
         repeat (2 + $urandom % 3)
            step();
      end
   endtask

   always @(posedge clk)
      irr_at_edge <= irr;

   always @(negedge clk)
   begin
      if (arst_n)
      begin
         flush_due = 1'b0;
         if (trace.slot[0].valid || trace.slot[1].valid)
            compare_irr($sformatf("irr at commit %0d", commit_idx), irr_at_edge, trace.irr);
         for (int s = 0; s < trace_pkg::commit_w; s++)
         begin
            if (trace.slot[s].valid)
               check_commit(s, trace.slot[s]);
         end
         // Flush runs while the excepting record sits on the trace port
         compare_level("flush", flush_due, flush);
         if (flush_due)
            compare_level("dispatch_ready during flush", 1'b0, dispatch_ready);
      end
   end

   initial
   begin
      wait (cases_loaded);
      repeat (case_count * 200)
         @(posedge clk);
      $display("Timeout, the run did not finish within %0d cycles", case_count * 200);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial
   begin
      void'($urandom(24));
      arst_n   = 1'b0;
      dispatch = '0;
      complete = '0;
      irr      = '0;
      fd = $fopen("testbench/commit_trace_cases.txt", "r");
      if (fd == 0)
      begin
         $display("Cannot open testbench/commit_trace_cases.txt for reading");
         $display("SOME TESTS FAILED");
         $finish;
      end
      else
      begin
         load_cases();
         $fclose(fd);
         cases_loaded = 1'b1;
         repeat (10)
            @(posedge clk);
         @(negedge clk);
         arst_n = 1'b1;
         run_cases();
         while (exp_slot_q.size() != 0)
            step();
         // Catch stray records
         repeat (10)
            step();
         $display("Errors: %0d slot, %0d irr, %0d order, %0d level, %0d assertion",
                  slot_errors, irr_errors, order_errors, level_errors,
                  i_dut.i_chk.fail_count);
         if (slot_errors + irr_errors + order_errors + level_errors +
             i_dut.i_chk.fail_count == 0)
            $display("ALL TESTS PASSED");
         else
            $display("SOME TESTS FAILED");
         $finish;
      end
   end

endmodule

// File: testbench/commit_trace_chk.sv
`timescale 1ns/10ps

module commit_trace_chk
(
   input logic                        clk,
   input logic                        arst_n,
   input trace_pkg::dispatch_bundle_t dispatch,
   input logic                        dispatch_ready,
   input trace_pkg::trace_rec_t       trace,
   input logic                        flush
);

   int unsigned fail_count = 0;

   // Slot 1 only fills behind slot 0
   slot_order: assert property (@(posedge clk) disable iff (!arst_n)
      trace.slot[1].valid |-> trace.slot[0].valid)
   else
   begin
      fail_count++;
      $error("trace slot 1 valid while slot 0 is empty");
   end

   no_dispatch_when_busy: assert property (@(posedge clk) disable iff (!arst_n)
      !dispatch_ready |-> !(dispatch.slot[0].valid || dispatch.slot[1].valid))
   else
   begin
      fail_count++;
      $error("dispatch slot valid while dispatch_ready is low");
   end

   // Nothing retires in the cycle after a flush
   quiet_after_flush: assert property (@(posedge clk) disable iff (!arst_n)
      flush |=> !(trace.slot[0].valid || trace.slot[1].valid))
   else
   begin
      fail_count++;
      $error("trace slot valid in the cycle after flush");
   end

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/10ps

module tb_clock
(
   output logic clk
);

   // 20 ns period
   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

endmodule

// File: logic/commit_trace_top.sv
`timescale 1ns/10ps

module commit_trace_top
(
   input  logic                                 clk,
   input  logic                                 arst_n,
   input  trace_pkg::dispatch_bundle_t          dispatch,
   input  trace_pkg::completion_t               complete,
   input  logic [trace_pkg::num_irq-1:0]        irr,
   output logic                                 dispatch_ready,
   output trace_pkg::trace_rec_t                trace,
   output logic                                 flush
);

   trace_pkg::head_status_t [trace_pkg::commit_w-1:0] head_status;
   trace_pkg::commit_sel_t        commit_sel;
   logic [1:0]                    push_count;
   logic [2:0]                    in_flight;
   logic [4:0]                    occupancy;
   logic [trace_pkg::seq_aw-1:0]  alloc_seq;
   logic [trace_pkg::seq_aw-1:0]  head_seq;

   rob_ptrs i_rob_ptrs
   (
      .clk            (clk),
      .arst_n         (arst_n),
      .push_count     (push_count),
      .commit_sel     (commit_sel),
      .flush          (flush),
      .alloc_seq      (alloc_seq),
      .head_seq       (head_seq),
      .occupancy      (occupancy)
   );

   commit_fsm i_commit_fsm
   (
      .clk            (clk),
      .arst_n         (arst_n),
      .head_status    (head_status),
      .occupancy      (occupancy),
      .in_flight      (in_flight),
      .commit_sel     (commit_sel),
      .flush          (flush),
      .dispatch_ready (dispatch_ready)
   );

   commit_shadow i_commit_shadow
   (
      .clk            (clk),
      .arst_n         (arst_n),
      .dispatch       (dispatch),
      .complete       (complete),
      .irr            (irr),
      .alloc_seq      (alloc_seq),
      .head_seq       (head_seq),
      .commit_sel     (commit_sel),
      .flush          (flush),
      .head_status    (head_status),
      .push_count     (push_count),
      .in_flight      (in_flight),
      .trace          (trace)
   );

endmodule

// File: logic/commit_shadow.sv
`timescale 1ns/10ps

module commit_shadow
(
   input  logic                                                 clk,
   input  logic                                                 arst_n,
   input  trace_pkg::dispatch_bundle_t                          dispatch,
   input  trace_pkg::completion_t                               complete,
   input  logic [trace_pkg::num_irq-1:0]                        irr,
   input  logic [trace_pkg::seq_aw-1:0]                         alloc_seq,
   input  logic [trace_pkg::seq_aw-1:0]                         head_seq,
   input  trace_pkg::commit_sel_t                               commit_sel,
   input  logic                                                 flush,
   output trace_pkg::head_status_t [trace_pkg::commit_w-1:0]    head_status,
   output logic [1:0]                                           push_count,
   output logic [2:0]                                           in_flight,
   output trace_pkg::trace_rec_t                                trace
);

   trace_pkg::dispatch_bundle_t rename_q;
   trace_pkg::dispatch_bundle_t issue_q;
   trace_pkg::rob_tag_t [trace_pkg::issue_w-1:0]  push_tag;
   trace_pkg::rob_tag_t [trace_pkg::commit_w-1:0] head_tag;
   logic [1:0]                  rename_count;
   trace_pkg::trace_rec_t       trace_d;
   trace_pkg::trace_rec_t       trace_q;

   logic [trace_pkg::commit_w-1:0][trace_pkg::bank_depth-1:0] present_q;
   logic [trace_pkg::commit_w-1:0][trace_pkg::bank_depth-1:0] complete_q;

   logic [trace_pkg::insn_w-1:0]  insn_mem  [trace_pkg::commit_w][trace_pkg::bank_depth];
   logic [trace_pkg::pc_w-1:0]    pc_mem    [trace_pkg::commit_w][trace_pkg::bank_depth];
   logic [trace_pkg::lrf_aw-1:0]  rd_mem    [trace_pkg::commit_w][trace_pkg::bank_depth];
   logic                          rd_we_mem [trace_pkg::commit_w][trace_pkg::bank_depth];
   logic [trace_pkg::data_w-1:0]  data_mem  [trace_pkg::commit_w][trace_pkg::bank_depth];
   logic                          exc_mem   [trace_pkg::commit_w][trace_pkg::bank_depth];
   logic [trace_pkg::cause_w-1:0] cause_mem [trace_pkg::commit_w][trace_pkg::bank_depth];

   function automatic trace_pkg::rob_tag_t to_tag(input logic [trace_pkg::seq_aw-1:0] seq);
      trace_pkg::rob_tag_t tag;
      tag.bank = seq[0];
      tag.id   = seq[trace_pkg::id_aw:1];
      return tag;
   endfunction

   // Rename and issue stand-ins, never stalled
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         rename_q <= '0;
         issue_q  <= '0;
      end
      else if (flush)
      begin
         rename_q <= '0;
         issue_q  <= '0;
      end
      else
      begin
         rename_q <= dispatch;
         issue_q  <= rename_q;
      end
   end

   always_comb
   begin
      logic [trace_pkg::seq_aw-1:0] seq;
      seq          = alloc_seq;
      push_count   = '0;
      rename_count = '0;
      for (int s = 0; s < trace_pkg::issue_w; s++)
      begin
         push_tag[s]  = to_tag(seq);
         seq          = seq + {{(trace_pkg::seq_aw-1){1'b0}}, issue_q.slot[s].valid};
         push_count   = push_count + 2'(issue_q.slot[s].valid);
         rename_count = rename_count + 2'(rename_q.slot[s].valid);
      end
   end

   assign in_flight = {1'b0, push_count} + {1'b0, rename_count};

   always_comb
   begin
      logic [trace_pkg::seq_aw-1:0] seq;
      seq = head_seq;
      for (int s = 0; s < trace_pkg::commit_w; s++)
      begin
         head_tag[s]             = to_tag(seq);
         head_status[s].present  = present_q[head_tag[s].bank][head_tag[s].id];
         head_status[s].complete = complete_q[head_tag[s].bank][head_tag[s].id];
         head_status[s].exc      = exc_mem[head_tag[s].bank][head_tag[s].id];
         seq = seq + {{(trace_pkg::seq_aw-1){1'b0}}, 1'b1};
      end
   end

   always_ff @(posedge clk)
   begin
      for (int s = 0; s < trace_pkg::issue_w; s++)
      begin
         if (issue_q.slot[s].valid && !flush)
         begin
            insn_mem[push_tag[s].bank][push_tag[s].id]  <= issue_q.slot[s].insn;
            pc_mem[push_tag[s].bank][push_tag[s].id]    <= issue_q.slot[s].pc;
            rd_mem[push_tag[s].bank][push_tag[s].id]    <= issue_q.slot[s].rd;
            rd_we_mem[push_tag[s].bank][push_tag[s].id] <= issue_q.slot[s].rd_we;
         end
      end
      if (complete.valid)
      begin
         data_mem[complete.tag.bank][complete.tag.id]  <= complete.data;
         exc_mem[complete.tag.bank][complete.tag.id]   <= complete.exc;
         cause_mem[complete.tag.bank][complete.tag.id] <= complete.cause;
      end
   end

   // Entry flags, completion set last so it wins over a same-cycle push
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         present_q  <= '0;
         complete_q <= '0;
      end
      else if (flush)
      begin
         present_q  <= '0;
         complete_q <= '0;
      end
      else
      begin
         for (int s = 0; s < trace_pkg::commit_w; s++)
         begin
            if (commit_sel.fire[s])
               present_q[head_tag[s].bank][head_tag[s].id] <= 1'b0;
         end
         for (int s = 0; s < trace_pkg::issue_w; s++)
         begin
            if (issue_q.slot[s].valid)
            begin
               present_q[push_tag[s].bank][push_tag[s].id]  <= 1'b1;
               complete_q[push_tag[s].bank][push_tag[s].id] <= 1'b0;
            end
         end
         if (complete.valid)
            complete_q[complete.tag.bank][complete.tag.id] <= 1'b1;
      end
   end

   always_comb
   begin
      trace_d     = '0;
      trace_d.irr = irr;
      for (int s = 0; s < trace_pkg::commit_w; s++)
      begin
         trace_d.slot[s].valid = commit_sel.fire[s];
         trace_d.slot[s].pc    = pc_mem[head_tag[s].bank][head_tag[s].id];
         trace_d.slot[s].insn  = insn_mem[head_tag[s].bank][head_tag[s].id];
         trace_d.slot[s].rd    = rd_mem[head_tag[s].bank][head_tag[s].id];
         trace_d.slot[s].rd_we = rd_we_mem[head_tag[s].bank][head_tag[s].id];
         trace_d.slot[s].data  = data_mem[head_tag[s].bank][head_tag[s].id];
      end
      // Only slot 0 can carry an exception
      trace_d.slot[0].excp = commit_sel.excp;
      if (commit_sel.excp)
         trace_d.slot[0].excp_vect = {cause_mem[head_tag[0].bank][head_tag[0].id], 2'b00};
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         trace_q <= '0;
      else
         trace_q <= trace_d;
   end

   assign trace = trace_q;

endmodule

// File: logic/commit_fsm.sv
`timescale 1ns/10ps

module commit_fsm
(
   input  logic                                                 clk,
   input  logic                                                 arst_n,
   input  trace_pkg::head_status_t [trace_pkg::commit_w-1:0]    head_status,
   input  logic [4:0]                                           occupancy,
   input  logic [2:0]                                           in_flight,
   output trace_pkg::commit_sel_t                               commit_sel,
   output logic                                                 flush,
   output logic                                                 dispatch_ready
);

   trace_pkg::commit_state_t     state_q;
   trace_pkg::commit_state_t     state_d;
   logic [trace_pkg::commit_w-1:0] head_ok;
   logic [5:0]                   pending;

   always_comb
   begin
      for (int s = 0; s < trace_pkg::commit_w; s++)
      begin
         head_ok[s] = head_status[s].present & head_status[s].complete;
      end
   end

   // Oldest entry first, an excepting entry retires alone
   always_comb
   begin
      commit_sel = '0;
      if (state_q == trace_pkg::st_run)
      begin
         commit_sel.fire[0] = head_ok[0];
         commit_sel.excp    = head_ok[0] & head_status[0].exc;
         commit_sel.fire[1] = head_ok[0] & ~head_status[0].exc &
                              head_ok[1] & ~head_status[1].exc;
      end
   end

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         trace_pkg::st_run:
         begin
            if (commit_sel.excp)
               state_d = trace_pkg::st_flush;
         end
         trace_pkg::st_flush:
         begin
            state_d = trace_pkg::st_run;
         end
         default:
         begin
            state_d = trace_pkg::st_run;
         end
      endcase
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         state_q <= trace_pkg::st_run;
      else
         state_q <= state_d;
   end

   assign flush = (state_q == trace_pkg::st_flush);

   // Leave room for a full bundle behind everything already counted
   assign pending        = {1'b0, occupancy} + {3'b000, in_flight};
   assign dispatch_ready = (state_q == trace_pkg::st_run) && (pending <= 6'd12);

endmodule

// File: logic/rob_ptrs.sv
`timescale 1ns/10ps

module rob_ptrs
(
   input  logic                           clk,
   input  logic                           arst_n,
   input  logic [1:0]                     push_count,
   input  trace_pkg::commit_sel_t         commit_sel,
   input  logic                           flush,
   output logic [trace_pkg::seq_aw-1:0]   alloc_seq,
   output logic [trace_pkg::seq_aw-1:0]   head_seq,
   output logic [4:0]                     occupancy
);

   logic [1:0]                   fired_count;
   logic [trace_pkg::seq_aw-1:0] push_ext;
   logic [trace_pkg::seq_aw-1:0] fired_ext;
   logic [trace_pkg::seq_aw-1:0] alloc_q;
   logic [trace_pkg::seq_aw-1:0] head_q;
   logic [4:0]                   occ_q;

   always_comb
   begin
      fired_count = '0;
      for (int s = 0; s < trace_pkg::commit_w; s++)
      begin
         fired_count = fired_count + 2'(commit_sel.fire[s]);
      end
   end

   assign push_ext  = {{(trace_pkg::seq_aw-2){1'b0}}, push_count};
   assign fired_ext = {{(trace_pkg::seq_aw-2){1'b0}}, fired_count};

   // Sequence numbers wrap modulo 16
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         alloc_q <= '0;
         head_q  <= '0;
         occ_q   <= '0;
      end
      else if (flush)
      begin
         alloc_q <= '0;
         head_q  <= '0;
         occ_q   <= '0;
      end
      else
      begin
         alloc_q <= alloc_q + push_ext;
         head_q  <= head_q + fired_ext;
         occ_q   <= occ_q + {3'b000, push_count} - {3'b000, fired_count};
      end
   end

   assign alloc_seq = alloc_q;
   assign head_seq  = head_q;
   assign occupancy = occ_q;

endmodule

// File: logic/trace_pkg.sv
package trace_pkg;

   localparam int insn_w     = 32;
   localparam int pc_w       = 30;
   localparam int lrf_aw     = 5;
   localparam int data_w     = 32;
   localparam int num_irq    = 8;
   localparam int issue_w    = 2;
   localparam int commit_w   = 2;
   localparam int bank_depth = 8;
   localparam int id_aw      = 3;
   localparam int seq_aw     = 4;
   localparam int cause_w    = 6;

   typedef enum logic {st_run, st_flush} commit_state_t;

   typedef struct packed {
      logic              valid;
      logic [insn_w-1:0] insn;
      logic [pc_w-1:0]   pc;
      logic [lrf_aw-1:0] rd;
      logic              rd_we;
   } dispatch_slot_t;

   typedef struct packed {
      dispatch_slot_t [issue_w-1:0] slot;
   } dispatch_bundle_t;

   // Bank is the low sequence bit
   typedef struct packed {
      logic             bank;
      logic [id_aw-1:0] id;
   } rob_tag_t;

   typedef struct packed {
      logic               valid;
      rob_tag_t           tag;
      logic [data_w-1:0]  data;
      logic               exc;
      logic [cause_w-1:0] cause;
   } completion_t;

   typedef struct packed {
      logic present;
      logic complete;
      logic exc;
   } head_status_t;

   typedef struct packed {
      logic [commit_w-1:0] fire;
      logic                excp;
   } commit_sel_t;

   typedef struct packed {
      logic              valid;
      logic [pc_w-1:0]   pc;
      logic [insn_w-1:0] insn;
      logic [lrf_aw-1:0] rd;
      logic              rd_we;
      logic [data_w-1:0] data;
      logic              excp;
      logic [7:0]        excp_vect;
   } trace_slot_t;

   typedef struct packed {
      trace_slot_t [commit_w-1:0] slot;
      logic [num_irq-1:0]         irr;
   } trace_rec_t;

endpackage
